/* compile.f */
+incdir+design
design/dsiq_pkg.sv
design/dsiq_word_packer.sv
design/dsiq_frame_fifo.sv
design/dsiq_sample_feeder.sv
design/dsiq_path.sv
bench/dsiq_path_tb.sv

/* Makefile */
# Verilator build and run for the downstream tx i/q path

VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= dsiq_path_tb
RTL_TOP   ?= dsiq_path
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

FAIL_MSG := Simulation failed
PASS_MSG := Simulation completed successfully
SOURCES  := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/dsiq_path_tb.sv */
`timescale 1ns/1ps
`include "dsiq_defines.svh"

module dsiq_path_tb;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 8;
  localparam int DEPTH         = 1 << `DSIQ_DEPTH_LOG2;
  localparam int LEVEL_TIMEOUT = 20;
  localparam int RUN_TIMEOUT   = 20000;
  localparam int NUM_TESTS     = 7;

  // one table row: frame length, strobes, pre-fill, strobes during arrival
  typedef struct packed {
    int   len;
    int   strobes;
    logic prefill;
    logic during;
  } test_t;

  logic                      clk_ctrl;
  logic                      arst_n_i;
  logic [7:0]                byte_i;
  logic                      byte_ctrl_i;
  logic                      byte_valid_i;
  logic                      frame_last_i;
  logic                      sample_stb_i;
  logic [15:0]               tx_i_o;
  logic [15:0]               tx_q_o;
  logic                      tx_ctrl_o;
  logic                      underrun_o;
  logic                      overflow_o;
  logic [`DSIQ_STATUS_W-1:0] level_o;

  integer seed;
  int     errors;
  int     checks;
  int     exp_urun;
  int     exp_ovf;
  int     urun_cnt = 0;
  int     ovf_cnt  = 0;
  int     wd_cycle;
  logic   exp_ctrl;
  logic   dropping;
  test_t  tests [NUM_TESTS];

  // buffer model, committed words and the frame still being written
  dsiq_pkg::iq_word_t commit_q [$];
  dsiq_pkg::iq_word_t pend_q [$];
  logic [7:0]         frame_data_q [$];
  logic               frame_ctrl_q [$];

  dsiq_path dsiq_path_i (
    .clk_ctrl     (clk_ctrl),
    .arst_n_i     (arst_n_i),
    .byte_i       (byte_i),
    .byte_ctrl_i  (byte_ctrl_i),
    .byte_valid_i (byte_valid_i),
    .frame_last_i (frame_last_i),
    .sample_stb_i (sample_stb_i),
    .tx_i_o       (tx_i_o),
    .tx_q_o       (tx_q_o),
    .tx_ctrl_o    (tx_ctrl_o),
    .underrun_o   (underrun_o),
    .overflow_o   (overflow_o),
    .level_o      (level_o)
  );

  always #(CLK_PERIOD / 2) clk_ctrl = ~clk_ctrl;

  // pulse counters, outputs are stable before the edge updates them
  always @(posedge clk_ctrl) begin
    if (arst_n_i) begin
      if (underrun_o) begin
        urun_cnt++;
      end
      if (overflow_o) begin
        ovf_cnt++;
      end
    end
  end

  // hang guard for the whole run
  initial begin
    for (wd_cycle = 0; wd_cycle < RUN_TIMEOUT; wd_cycle++) begin
      @(posedge clk_ctrl);
    end
    $display("timeout: the test sequence did not finish within %0d clock cycles", RUN_TIMEOUT);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // checking and model
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %0t ns: %s expected 0x%0h, got 0x%0h", $time, what, expected, actual);
    end
  endtask

  task automatic check_idle_outputs(input string when);
    check_value({"tx_i_o ", when}, 32'd0, 32'(tx_i_o));
    check_value({"tx_q_o ", when}, 32'd0, 32'(tx_q_o));
    check_value({"tx_ctrl_o ", when}, 32'd0, 32'(tx_ctrl_o));
    check_value({"underrun_o ", when}, 32'd0, 32'(underrun_o));
    check_value({"overflow_o ", when}, 32'd0, 32'(overflow_o));
    check_value({"level_o ", when}, 32'd0, 32'(level_o));
  endtask

  // space counts tentative words, a full buffer abandons the whole frame
  task automatic push_word(input dsiq_pkg::iq_word_t w, input logic last);
    if (dropping) begin
      if (last) begin
        dropping = 1'b0;
      end
    end else if (commit_q.size() + pend_q.size() == DEPTH) begin
      pend_q.delete();
      dropping = !last;
      exp_ovf++;
    end else begin
      pend_q.push_back(w);
      if (last) begin
        while (pend_q.size() > 0) begin
          commit_q.push_back(pend_q.pop_front());
        end
      end
    end
  endtask

  // lanes fill in arrival order, a short last word stays zero padded
  task automatic model_frame();
    dsiq_pkg::iq_word_t w;
    logic [1:0]         lane;
    logic               last;
    int                 b;
    w = '0;
    for (b = 0; b < frame_data_q.size(); b++) begin
      lane = 2'(b % `DSIQ_LANES);
      last = (b == frame_data_q.size() - 1);
      if (lane == 2'd0) begin
        w = '0;
      end
      w[lane].data = frame_data_q[b];
      w[lane].ctrl = frame_ctrl_q[b];
      if (lane == 2'(`DSIQ_LANES - 1) || last) begin
        push_word(w, last);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_for_level(input int expected, inout int cycles);
    while (32'(level_o) != expected && cycles < LEVEL_TIMEOUT) begin
      @(posedge clk_ctrl);
      @(negedge clk_ctrl);
      cycles++;
    end
    if (32'(level_o) != expected) begin
      errors++;
      $display("timeout: level_o did not reach %0d within %0d cycles", expected, LEVEL_TIMEOUT);
    end
  endtask

  task automatic send_frame(input int len, input logic during, input int n_stb);
    int level_before;
    int exp_level;
    int cycles;
    int b;
    level_before = commit_q.size();
    frame_data_q.delete();
    frame_ctrl_q.delete();
    for (b = 0; b < len; b++) begin
      frame_data_q.push_back(8'($random(seed)));
      frame_ctrl_q.push_back(1'($random(seed)));
      @(posedge clk_ctrl);
      byte_i       <= frame_data_q[b];
      byte_ctrl_i  <= frame_ctrl_q[b];
      byte_valid_i <= 1'b1;
      frame_last_i <= (b == len - 1);
      sample_stb_i <= during && (b < n_stb);
      @(negedge clk_ctrl);
      // an open frame adds nothing to the level
      check_value("level_o during arrival", 32'(level_before), 32'(level_o));
      if (during && underrun_o) begin
        check_value("tx_i_o on underrun", 32'd0, 32'(tx_i_o));
        check_value("tx_q_o on underrun", 32'd0, 32'(tx_q_o));
        check_value("tx_ctrl_o on underrun", 32'(exp_ctrl), 32'(tx_ctrl_o));
      end
    end
    @(posedge clk_ctrl);
    byte_valid_i <= 1'b0;
    frame_last_i <= 1'b0;
    sample_stb_i <= 1'b0;
    if (during) begin
      exp_urun += n_stb;
    end
    model_frame();
    exp_level = commit_q.size();
    @(negedge clk_ctrl);
    cycles = 1;
    if (exp_level != level_before) begin
      wait_for_level(exp_level, cycles);
      check_value("cycles from last byte to commit", 32'd2, 32'(cycles));
    end else begin
      @(posedge clk_ctrl);
      @(negedge clk_ctrl);
    end
    check_value("level_o after frame", 32'(exp_level), 32'(level_o));
  endtask

  task automatic do_strobe();
    dsiq_pkg::iq_word_t w;
    @(posedge clk_ctrl);
    sample_stb_i <= 1'b1;
    @(posedge clk_ctrl);
    sample_stb_i <= 1'b0;
    @(negedge clk_ctrl);
    if (commit_q.size() > 0) begin
      w = commit_q.pop_front();
      check_value("tx_i_o", 32'({w[0].data, w[1].data}), 32'(tx_i_o));
      check_value("tx_q_o", 32'({w[2].data, w[3].data}), 32'(tx_q_o));
      check_value("tx_ctrl_o", 32'(w[3].ctrl), 32'(tx_ctrl_o));
      check_value("underrun_o after pop", 32'd0, 32'(underrun_o));
      exp_ctrl = w[3].ctrl;
    end else begin
      check_value("tx_i_o on underrun", 32'd0, 32'(tx_i_o));
      check_value("tx_q_o on underrun", 32'd0, 32'(tx_q_o));
      check_value("tx_ctrl_o held on underrun", 32'(exp_ctrl), 32'(tx_ctrl_o));
      check_value("underrun_o on empty buffer", 32'd1, 32'(underrun_o));
      exp_urun++;
    end
    check_value("level_o after strobe", 32'(commit_q.size()), 32'(level_o));
  endtask

  // leaves two free words, so a four-word frame cannot fit
  task automatic prefill_buffer();
    int room;
    while (commit_q.size() < DEPTH - 2) begin
      room = DEPTH - 2 - commit_q.size();
      if (room > 16) begin
        room = 16;
      end
      send_frame(room * `DSIQ_LANES, 1'b0, 0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int t;
    int s;
    int err_before;
    int passed;
    int failed;
    clk_ctrl     = 1'b0;
    arst_n_i     = 1'b0;
    byte_i       = 8'd0;
    byte_ctrl_i  = 1'b0;
    byte_valid_i = 1'b0;
    frame_last_i = 1'b0;
    sample_stb_i = 1'b0;
    seed         = 57982;
    errors       = 0;
    checks       = 0;
    exp_urun     = 0;
    exp_ovf      = 0;
    exp_ctrl     = 1'b0;
    dropping     = 1'b0;
    passed       = 0;
    failed       = 0;

    tests[0] = '{len: 16, strobes: 4, prefill: 1'b0, during: 1'b0};
    tests[1] = '{len: 32, strobes: 8, prefill: 1'b0, during: 1'b0};
    tests[2] = '{len: 10, strobes: 3, prefill: 1'b0, during: 1'b0};
    tests[3] = '{len: 7, strobes: 2, prefill: 1'b0, during: 1'b0};
    tests[4] = '{len: 24, strobes: 12, prefill: 1'b0, during: 1'b1};
    tests[5] = '{len: 16, strobes: 0, prefill: 1'b1, during: 1'b0};
    tests[6] = '{len: 8, strobes: 260, prefill: 1'b0, during: 1'b0};

    // reset state, then a few idle cycles without any pulse
    for (s = 0; s < RESET_CYCLES; s++) begin
      @(negedge clk_ctrl);
      check_idle_outputs("in reset");
    end
    @(posedge clk_ctrl);
    arst_n_i <= 1'b1;
    for (s = 0; s < 3; s++) begin
      @(negedge clk_ctrl);
      check_idle_outputs("after reset");
    end
    check_value("pulses before first input", 32'd0, 32'(urun_cnt + ovf_cnt));
    if (errors == 0) begin
      passed++;
    end else begin
      failed++;
    end
    $display("test reset: %s", (errors == 0) ? "ok" : "mismatch");

    for (t = 0; t < NUM_TESTS; t++) begin
      err_before = errors;
      if (tests[t].prefill) begin
        prefill_buffer();
      end
      send_frame(tests[t].len, tests[t].during, tests[t].strobes);
      if (!tests[t].during) begin
        for (s = 0; s < tests[t].strobes; s++) begin
          do_strobe();
        end
      end
      repeat (2) @(posedge clk_ctrl);
      @(negedge clk_ctrl);
      check_value("underrun pulse count", 32'(exp_urun), 32'(urun_cnt));
      check_value("overflow pulse count", 32'(exp_ovf), 32'(ovf_cnt));
      if (errors == err_before) begin
        passed++;
      end else begin
        failed++;
      end
      $display("test %0d (len %0d, strobes %0d, prefill %0d, during arrival %0d): %s",
               t, tests[t].len, tests[t].strobes, tests[t].prefill, tests[t].during,
               (errors == err_before) ? "ok" : "mismatch");
    end

    $display("tests: %0d passed, %0d with errors, %0d checks, %0d errors",
             passed, failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* design/dsiq_path.sv */
`timescale 1ns/1ps
`include "dsiq_defines.svh"

module dsiq_path (
  input  logic                      clk_ctrl,
  input  logic                      arst_n_i,
  // ethernet receive side
  input  logic [7:0]                byte_i,
  input  logic                      byte_ctrl_i,
  input  logic                      byte_valid_i,
  input  logic                      frame_last_i,
  // radio side
  input  logic                      sample_stb_i,
  output logic [15:0]               tx_i_o,
  output logic [15:0]               tx_q_o,
  output logic                      tx_ctrl_o,
  output logic                      underrun_o,
  output logic                      overflow_o,
  output logic [`DSIQ_STATUS_W-1:0] level_o
);

  dsiq_pkg::iq_word_t   word;
  logic                 word_valid;
  logic                 word_last;
  dsiq_pkg::iq_word_t   rd_word;
  logic                 rd_valid;
  logic                 pop;
  dsiq_pkg::iq_sample_t sample;

  //////////////////////////////////////////////////////////////////////
  // byte packing into four-lane words
  //////////////////////////////////////////////////////////////////////

  dsiq_word_packer dsiq_word_packer_i (
    .clk_ctrl     (clk_ctrl),
    .arst_n_i     (arst_n_i),
    .byte_i       (byte_i),
    .byte_ctrl_i  (byte_ctrl_i),
    .byte_valid_i (byte_valid_i),
    .frame_last_i (frame_last_i),
    .word_o       (word),
    .word_valid_o (word_valid),
    .word_last_o  (word_last)
  );

  //////////////////////////////////////////////////////////////////////
  // whole-frame buffer
  //////////////////////////////////////////////////////////////////////

  dsiq_frame_fifo dsiq_frame_fifo_i (
    .clk_ctrl     (clk_ctrl),
    .arst_n_i     (arst_n_i),
    .word_i       (word),
    .word_valid_i (word_valid),
    .word_last_i  (word_last),
    .pop_i        (pop),
    .rd_word_o    (rd_word),
    .rd_valid_o   (rd_valid),
    .overflow_o   (overflow_o),
    .level_o      (level_o)
  );

  //////////////////////////////////////////////////////////////////////
  // sample strobe side
  //////////////////////////////////////////////////////////////////////

  dsiq_sample_feeder dsiq_sample_feeder_i (
    .clk_ctrl     (clk_ctrl),
    .arst_n_i     (arst_n_i),
    .sample_stb_i (sample_stb_i),
    .rd_word_i    (rd_word),
    .rd_valid_i   (rd_valid),
    .pop_o        (pop),
    .sample_o     (sample),
    .tx_ctrl_o    (tx_ctrl_o),
    .underrun_o   (underrun_o)
  );

  assign tx_i_o = sample.i;
  assign tx_q_o = sample.q;

endmodule

/* design/dsiq_sample_feeder.sv */
`timescale 1ns/1ps

module dsiq_sample_feeder (
  input  logic                 clk_ctrl,
  input  logic                 arst_n_i,
  input  logic                 sample_stb_i,
  input  dsiq_pkg::iq_word_t   rd_word_i,
  input  logic                 rd_valid_i,
  output logic                 pop_o,
  output dsiq_pkg::iq_sample_t sample_o,
  output logic                 tx_ctrl_o,
  output logic                 underrun_o
);

  //////////////////////////////////////////////////////////////////////
  // pop and split
  //////////////////////////////////////////////////////////////////////

  // word leaves the buffer on the same edge that registers it here
  assign pop_o = sample_stb_i && rd_valid_i;

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sample_o   <= '0;
      tx_ctrl_o  <= 1'b0;
      underrun_o <= 1'b0;
    end else begin
      underrun_o <= 1'b0;
      if (pop_o) begin
        // first byte of each pair is the high byte
        sample_o.i <= {rd_word_i[0].data, rd_word_i[1].data};
        sample_o.q <= {rd_word_i[2].data, rd_word_i[3].data};
        tx_ctrl_o  <= rd_word_i[3].ctrl;
      end else if (sample_stb_i) begin
        // starved, send silence and keep the last control state
        sample_o   <= '0;
        underrun_o <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_pop_with_valid: assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    pop_o |-> rd_valid_i)
    else $error("feeder popped without a valid word");

endmodule

/* design/dsiq_frame_fifo.sv */
`timescale 1ns/1ps
`include "dsiq_defines.svh"

module dsiq_frame_fifo (
  input  logic                      clk_ctrl,
  input  logic                      arst_n_i,
  input  dsiq_pkg::iq_word_t        word_i,
  input  logic                      word_valid_i,
  input  logic                      word_last_i,
  input  logic                      pop_i,
  output dsiq_pkg::iq_word_t        rd_word_o,
  output logic                      rd_valid_o,
  output logic                      overflow_o,
  output logic [`DSIQ_STATUS_W-1:0] level_o
);

  localparam int ADDR_W = `DSIQ_DEPTH_LOG2;
  localparam int PTR_W  = `DSIQ_DEPTH_LOG2 + 1;
  localparam int DEPTH  = 1 << `DSIQ_DEPTH_LOG2;

  dsiq_pkg::iq_word_t mem [DEPTH];

  // pointers carry one extra bit so full and empty differ
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] commit_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] used;
  logic             full;
  logic             drop_q;
  logic             wr_en;

  //////////////////////////////////////////////////////////////////////
  // occupancy
  //////////////////////////////////////////////////////////////////////

  // tentative words count against space, only committed ones are readable
  assign used       = wr_ptr - rd_ptr;
  assign full       = (used == PTR_W'(DEPTH));
  assign rd_valid_o = (commit_ptr != rd_ptr);
  assign level_o    = `DSIQ_STATUS_W'(commit_ptr - rd_ptr);

  assign wr_en = word_valid_i && !drop_q && !full;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_W-1:0]] <= word_i;
    end
  end

  // read word is available while valid, the feeder samples it on pop
  assign rd_word_o = mem[rd_ptr[ADDR_W-1:0]];

  //////////////////////////////////////////////////////////////////////
  // write side, commit and drop
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      drop_q     <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      overflow_o <= 1'b0;
      if (word_valid_i) begin
        if (drop_q) begin
          // skip the rest of an abandoned frame
          if (word_last_i) begin
            drop_q <= 1'b0;
          end
        end else if (full) begin
          // roll back to the last committed frame
          wr_ptr     <= commit_ptr;
          drop_q     <= !word_last_i;
          overflow_o <= 1'b1;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
          if (word_last_i) begin
            commit_ptr <= wr_ptr + 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr <= '0;
    end else if (pop_i && rd_valid_o) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // the feeder must never pop an empty buffer
  a_pop_not_empty: assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    pop_i |-> rd_valid_o)
    else $error("frame buffer popped while empty");

  a_level_bound: assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    level_o <= `DSIQ_STATUS_W'(DEPTH))
    else $error("frame buffer level above depth");

endmodule

/* design/dsiq_word_packer.sv */
`timescale 1ns/1ps
`include "dsiq_defines.svh"

module dsiq_word_packer (
  input  logic               clk_ctrl,
  input  logic               arst_n_i,
  input  logic [7:0]         byte_i,
  input  logic               byte_ctrl_i,
  input  logic               byte_valid_i,
  input  logic               frame_last_i,
  output dsiq_pkg::iq_word_t word_o,
  output logic               word_valid_o,
  output logic               word_last_o
);

  localparam int LANE_W = $clog2(`DSIQ_LANES);

  logic [LANE_W-1:0]  lane_cnt;
  logic               lane_end;
  dsiq_pkg::iq_lane_t lane_in;
  dsiq_pkg::iq_word_t word_d;
  dsiq_pkg::iq_word_t word_q;

  //////////////////////////////////////////////////////////////////////
  // lane fill
  //////////////////////////////////////////////////////////////////////

  // word closes on the top lane or on the last byte of a frame
  assign lane_end = frame_last_i || (lane_cnt == LANE_W'(`DSIQ_LANES - 1));

  always_comb begin
    lane_in.ctrl = byte_ctrl_i;
    lane_in.data = byte_i;
    // a fresh word starts from zero, so a short word comes out padded
    word_d = (lane_cnt == '0) ? '0 : word_q;
    word_d[lane_cnt] = lane_in;
  end

  always_ff @(posedge clk_ctrl) begin
    if (byte_valid_i) begin
      word_q <= word_d;
    end
  end

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_cnt     <= '0;
      word_valid_o <= 1'b0;
      word_last_o  <= 1'b0;
    end else begin
      word_valid_o <= 1'b0;
      word_last_o  <= 1'b0;
      if (byte_valid_i) begin
        if (lane_end) begin
          lane_cnt     <= '0;
          word_valid_o <= 1'b1;
          word_last_o  <= frame_last_i;
        end else begin
          lane_cnt <= lane_cnt + 1'b1;
        end
      end
    end
  end

  assign word_o = word_q;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_lane_range: assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    int'(lane_cnt) < `DSIQ_LANES)
    else $error("packer lane counter out of range");

endmodule

/* design/dsiq_pkg.sv */
`include "dsiq_defines.svh"

package dsiq_pkg;

  //////////////////////////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////////////////////////

  // one received byte with its control bit on top
  typedef struct packed {
    logic       ctrl;
    logic [7:0] data;
  } iq_lane_t;

  // lane 0 sits in the low bits and holds the first byte received
  typedef iq_lane_t [`DSIQ_LANES-1:0] iq_word_t;

  // sample as presented to the dac side
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } iq_sample_t;

endpackage

/* design/dsiq_defines.svh */
`ifndef DSIQ_DEFINES_SVH
`define DSIQ_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// downstream tx i/q path sizing
//////////////////////////////////////////////////////////////////////

// log2 of the frame buffer depth in words
`define DSIQ_DEPTH_LOG2 8

// byte lanes per buffered word
// four lanes carry one 16-bit I and one 16-bit Q value
`define DSIQ_LANES 4

// width of the level report
// one bit wider than the address so a completely full buffer fits
`define DSIQ_STATUS_W 9

`endif
